/* logic/execPkg.sv */
// Execute stage shared definitions.
// Function codes for the SPECIAL and SPECIAL2 groups, the decoded function
// field, internal ALU and HI/LO operation codes, and the control and flag
// structs passed between the stage blocks.

`default_nettype none

package execPkg;

    // ------------------------------
    // Function field encodings
    // ------------------------------
    typedef enum logic [5:0] {
        SLL   = 6'h00, SRL   = 6'h02, SRA   = 6'h03,
        SLLV  = 6'h04, SRLV  = 6'h06, SRAV  = 6'h07,
        JR    = 6'h08, JALR  = 6'h09,
        MFHI  = 6'h10, MTHI  = 6'h11, MFLO  = 6'h12, MTLO  = 6'h13,
        MULT  = 6'h18, MULTU = 6'h19,
        ADD   = 6'h20, ADDU  = 6'h21, SUB   = 6'h22, SUBU  = 6'h23,
        AND   = 6'h24, OR    = 6'h25, XOR   = 6'h26, NOR   = 6'h27,
        SLT   = 6'h2A, SLTU  = 6'h2B
    } specialFunc;

    typedef enum logic [5:0] {
        MADD  = 6'h00, MADDU = 6'h01, MUL   = 6'h02,
        MSUB  = 6'h04, MSUBU = 6'h05,
        CLZ   = 6'h20, CLO   = 6'h21
    } special2Func;

    // Same six bits, read per opcode group.
    typedef union packed {
        specialFunc  special;  // When ALUOp is set.
        special2Func special2; // When MULOp is set.
    } funcField;

    // ------------------------------
    // Internal operation codes
    // ------------------------------
    typedef enum logic [3:0] {
        aluAdd, aluAddUnsigned, aluSub, aluSubUnsigned,
        aluAnd, aluOr, aluXor, aluNor,
        aluSetLess, aluSetLessUnsigned,
        aluShiftLeft, aluShiftRightLogical, aluShiftRightArith,
        aluCountZeros, aluCountOnes
    } aluOp;

    // mulWrite loads HI:LO from the two operands as given.
    typedef enum logic [2:0] {
        mulNone, mulMult, mulMultUnsigned,
        mulMadd, mulMaddUnsigned, mulMsub, mulMsubUnsigned,
        mulWrite
    } mulOp;

    // ------------------------------
    // Control and status words
    // ------------------------------
    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memToReg;
    } memCtrl;

    typedef struct packed {
        logic carry;
        logic zero;
        logic overflow;
        logic negative;
    } flags;

endpackage

`default_nettype wire

/* logic/aluUnit.sv */
// Integer ALU for the execute stage.
// Shifts, add and subtract on one 33-bit adder, logic ops,
// set-less-than and leading zero/one counts. Purely combinational.

`timescale 1ns/10ps
`default_nettype none

module aluUnit
    import execPkg::*;
(
    input  wire aluOp         operation,
    input  wire logic [31:0]  a,
    input  wire logic [31:0]  b,
    input  wire logic [4:0]   shiftAmount,
    output logic      [31:0]  result,
    output flags              status
);

    logic        subtract;
    logic [31:0] addend;
    logic [32:0] sum;
    logic        signedOverflow;
    logic        lessSigned;
    logic        lessUnsigned;
    logic        arithmetic;
    logic        signedArithmetic;

    // Number of leading zeros, 32 for a zero word.
    function automatic logic [31:0] leadingZeros(input logic [31:0] value);
        logic [31:0] count;
        int          i;
        count = 32'd32;
        for (i = 0; i < 32; i++)
        begin
            if (value[i])
                count = 32'd31 - 32'(i); // Highest set bit wins.
        end
        return count;
    endfunction

    // ------------------------------
    // Shared adder
    // ------------------------------
    assign subtract = (operation == aluSub) || (operation == aluSubUnsigned) ||
                      (operation == aluSetLess) || (operation == aluSetLessUnsigned);

    assign addend = subtract ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, addend} + {32'd0, subtract};

    // Operands of equal sign giving a result of the other sign.
    assign signedOverflow = (a[31] == addend[31]) && (sum[31] != a[31]);

    assign lessSigned   = sum[31] ^ signedOverflow;
    assign lessUnsigned = ~sum[32]; // Borrow out.

    // ------------------------------
    // Result select
    // ------------------------------
    always_comb
    begin
        case (operation)
            aluAdd, aluAddUnsigned,
            aluSub, aluSubUnsigned:
                result = sum[31:0];
            aluAnd:
                result = a & b;
            aluOr:
                result = a | b;
            aluXor:
                result = a ^ b;
            aluNor:
                result = ~(a | b);
            aluSetLess:
                result = {31'd0, lessSigned};
            aluSetLessUnsigned:
                result = {31'd0, lessUnsigned};
            aluShiftLeft:
                result = b << shiftAmount;
            aluShiftRightLogical:
                result = b >> shiftAmount;
            aluShiftRightArith:
                result = $unsigned($signed(b) >>> shiftAmount);
            aluCountZeros:
                result = leadingZeros(a);
            aluCountOnes:
                result = leadingZeros(~a); // Leading ones of a.
            default:
                result = '0;
        endcase
    end

    // ------------------------------
    // Flags
    // ------------------------------
    assign arithmetic = (operation == aluAdd) || (operation == aluAddUnsigned) ||
                        (operation == aluSub) || (operation == aluSubUnsigned);

    // Only the trapping forms report overflow.
    assign signedArithmetic = (operation == aluAdd) || (operation == aluSub);

    assign status = '{
        carry:    arithmetic & sum[32],
        zero:     (result == 32'd0),
        overflow: signedArithmetic & signedOverflow,
        negative: result[31]
    };

endmodule

`default_nettype wire

/* logic/mulUnit.sv */
// HI/LO multiply unit.
// Signed and unsigned 32x32 multiply into HI:LO, multiply-accumulate
// and multiply-subtract, and direct HI:LO loads. Flags describe the
// value being written, or the low product word when nothing is written.

`timescale 1ns/10ps
`default_nettype none

module mulUnit
    import execPkg::*;
(
    input  wire logic         Clock,
    input  wire logic         reset,
    input  wire mulOp         operation,
    input  wire logic [31:0]  a,
    input  wire logic [31:0]  b,
    output logic      [31:0]  hi,
    output logic      [31:0]  lo,
    output logic      [31:0]  product,
    output flags              status
);

    logic [63:0] signedProduct;
    logic [63:0] unsignedProduct;
    logic [63:0] accumulator;
    logic [63:0] nextValue;
    logic        writeEnable;
    logic        accOverflow;

    assign signedProduct   = $signed(a) * $signed(b); // Sign-extended to 64 bits.
    assign unsignedProduct = a * b;
    assign accumulator     = {hi, lo};
    assign product         = signedProduct[31:0]; // Word for MUL.

    always_comb
    begin
        nextValue   = accumulator;
        writeEnable = 1'b1;
        accOverflow = 1'b0;
        case (operation)
            mulMult:         nextValue = signedProduct;
            mulMultUnsigned: nextValue = unsignedProduct;
            mulMadd:
            begin
                nextValue   = accumulator + signedProduct;
                accOverflow = (accumulator[63] == signedProduct[63]) &&
                              (nextValue[63] != accumulator[63]);
            end
            mulMaddUnsigned: nextValue = accumulator + unsignedProduct;
            mulMsub:
            begin
                nextValue   = accumulator - signedProduct;
                accOverflow = (accumulator[63] != signedProduct[63]) &&
                              (nextValue[63] != accumulator[63]);
            end
            mulMsubUnsigned: nextValue = accumulator - unsignedProduct;
            mulWrite:        nextValue = {a, b};
            default:         writeEnable = 1'b0; // HI:LO hold.
        endcase
    end

    // Flags for the current operation.
    always_comb
    begin
        status.carry = 1'b0;
        if (writeEnable)
        begin
            status.zero     = (nextValue == 64'd0);
            status.overflow = accOverflow;
            status.negative = nextValue[63];
        end
        else
        begin
            // Product must fit in 32 signed bits.
            status.zero     = (signedProduct[31:0] == 32'd0);
            status.overflow = (signedProduct[63:32] != {32{signedProduct[31]}});
            status.negative = signedProduct[31];
        end
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
            {hi, lo} <= '0;
        else if (writeEnable)
            {hi, lo} <= nextValue;
    end

endmodule

`default_nettype wire

/* logic/execControl.sv */
// Execute stage control.
// Decodes the function field per opcode group, steers operands to the ALU
// and multiply units, picks the result source, and holds the
// execute/memory pipeline register.

`timescale 1ns/10ps
`default_nettype none

module execControl
    import execPkg::*;
(
    input  wire logic         Clock,
    input  wire logic         reset,
    input  wire logic         ALUOp,
    input  wire logic         MULOp,
    input  wire logic         Jump,
    input  wire logic         Branch,
    input  wire logic         ALUSrc,
    input  wire logic [31:0]  pc,
    input  wire logic [31:0]  a,
    input  wire logic [31:0]  b,
    input  wire logic [31:0]  immediate,
    input  wire logic [4:0]   shamt,
    input  wire funcField     func,
    input  wire memCtrl       memIn,
    output aluOp              aluOperation,
    output logic      [31:0]  aluA,
    output logic      [31:0]  aluB,
    output logic      [4:0]   shiftAmount,
    input  wire logic [31:0]  aluResult,
    input  wire flags         aluFlags,
    output mulOp              mulOperation,
    output logic      [31:0]  mulA,
    output logic      [31:0]  mulB,
    input  wire logic [31:0]  hi,
    input  wire logic [31:0]  lo,
    input  wire logic [31:0]  product,
    input  wire flags         mulFlags,
    output logic      [31:0]  result,
    output flags              flagsOut,
    output memCtrl            memOut,
    output logic      [31:0]  pcOut
);

    logic [31:0] operandB;
    logic [31:0] linkAddress;
    logic        useAlu;
    logic        useMul;
    logic [31:0] nextResult;
    flags        nextFlags;
    memCtrl      nextMem;

    assign operandB    = ALUSrc ? immediate : b;
    assign linkAddress = pc + 32'd8; // Past the delay slot.

    assign aluA = a;
    assign aluB = operandB;

    // ------------------------------
    // Decode
    // ------------------------------
    always_comb
    begin
        aluOperation = aluAdd;
        shiftAmount  = shamt;
        mulOperation = mulNone;
        mulA         = a;
        mulB         = operandB;
        useAlu       = 1'b0;
        useMul       = 1'b0; // Take multiply flags.
        nextResult   = '0;
        nextMem      = memIn;

        if (ALUOp)
        begin
            useAlu = 1'b1;
            case (func.special)
                SLL:  aluOperation = aluShiftLeft;
                SRL:  aluOperation = aluShiftRightLogical;
                SRA:  aluOperation = aluShiftRightArith;
                SLLV, SRLV, SRAV:
                begin
                    shiftAmount  = a[4:0]; // Variable shifts use rs.
                    aluOperation = (func.special == SLLV) ? aluShiftLeft :
                                   (func.special == SRLV) ? aluShiftRightLogical :
                                                            aluShiftRightArith;
                end
                ADD:  aluOperation = aluAdd;
                ADDU: aluOperation = aluAddUnsigned;
                SUB:  aluOperation = aluSub;
                SUBU: aluOperation = aluSubUnsigned;
                AND:  aluOperation = aluAnd;
                OR:   aluOperation = aluOr;
                XOR:  aluOperation = aluXor;
                NOR:  aluOperation = aluNor;
                SLT:  aluOperation = aluSetLess;
                SLTU: aluOperation = aluSetLessUnsigned;
                default:
                begin
                    useAlu = 1'b0;
                    // HI/LO writers leave the register file alone.
                    if (func.special inside {MULT, MULTU, MTHI, MTLO})
                    begin
                        useMul           = 1'b1;
                        nextMem.regWrite = 1'b0;
                    end
                    case (func.special)
                        MULT:  mulOperation = mulMult;
                        MULTU: mulOperation = mulMultUnsigned;
                        MTHI:
                        begin
                            mulOperation = mulWrite;
                            mulA         = a;
                            mulB         = lo;
                        end
                        MTLO:
                        begin
                            mulOperation = mulWrite;
                            mulA         = hi;
                            mulB         = a;
                        end
                        MFHI:     nextResult = hi;
                        MFLO:     nextResult = lo;
                        JR, JALR: nextResult = linkAddress;
                        default:  nextResult = '0;
                    endcase
                end
            endcase
        end
        else if (MULOp)
        begin
            useMul = 1'b1;
            case (func.special2)
                MUL:   nextResult = product; // Low word, no HI/LO write.
                MADD:  mulOperation = mulMadd;
                MADDU: mulOperation = mulMaddUnsigned;
                MSUB:  mulOperation = mulMsub;
                MSUBU: mulOperation = mulMsubUnsigned;
                CLZ, CLO:
                begin
                    useMul       = 1'b0;
                    useAlu       = 1'b1;
                    aluOperation = (func.special2 == CLZ) ? aluCountZeros : aluCountOnes;
                end
                default: useMul = 1'b0;
            endcase
            if (mulOperation != mulNone)
                nextMem.regWrite = 1'b0;
        end
        else if (Branch)
        begin
            aluOperation = aluSub; // Z set means equal.
            useAlu       = 1'b1;
        end

        if (useAlu)
            nextResult = aluResult;

        if (Jump)
        begin
            nextResult       = linkAddress;
            nextMem.regWrite = 1'b1;
        end
    end

    // Flags follow the unit that produced the result.
    assign nextFlags = Jump   ? '0       :
                       useAlu ? aluFlags :
                       useMul ? mulFlags : '0;

    // ------------------------------
    // Execute/memory register
    // ------------------------------
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            result   <= '0;
            flagsOut <= '0;
            memOut   <= '0;
            pcOut    <= '0;
        end
        else
        begin
            result   <= nextResult;
            flagsOut <= nextFlags;
            memOut   <= nextMem;
            pcOut    <= pc;
        end
    end

endmodule

`default_nettype wire

/* logic/executeStage.sv */
// Execute stage top level.
// Joins the decode/steering control with the integer ALU and the
// HI/LO multiply unit. One cycle from inputs to registered outputs.

`timescale 1ns/10ps
`default_nettype none

module executeStage
    import execPkg::*;
(
    input  wire logic         Clock,
    input  wire logic         reset,
    input  wire logic         ALUOp,
    input  wire logic         MULOp,
    input  wire logic         Jump,
    input  wire logic         Branch,
    input  wire logic         ALUSrc,
    input  wire logic [31:0]  pc,
    input  wire logic [31:0]  a,
    input  wire logic [31:0]  b,
    input  wire logic [31:0]  immediate,
    input  wire logic [4:0]   shamt,
    input  wire funcField     func,
    input  wire memCtrl       memIn,
    output logic      [31:0]  result,
    output flags              flagsOut,
    output memCtrl            memOut,
    output logic      [31:0]  pcOut
);

    // ALU side.
    aluOp        aluOperation;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [4:0]  shiftAmount;
    logic [31:0] aluResult;
    flags        aluFlags;

    // Multiply side.
    mulOp        mulOperation;
    logic [31:0] mulA;
    logic [31:0] mulB;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] product;
    flags        mulFlags;

    execControl control (
        .Clock, .reset, .ALUOp, .MULOp, .Jump, .Branch, .ALUSrc,
        .pc, .a, .b, .immediate, .shamt, .func, .memIn,
        .aluOperation, .aluA, .aluB, .shiftAmount, .aluResult, .aluFlags,
        .mulOperation, .mulA, .mulB, .hi, .lo, .product, .mulFlags,
        .result, .flagsOut, .memOut, .pcOut
    );

    aluUnit alu (
        .operation   (aluOperation),
        .a           (aluA),
        .b           (aluB),
        .shiftAmount (shiftAmount),
        .result      (aluResult),
        .status      (aluFlags)
    );

    mulUnit multiplier (
        .Clock     (Clock),
        .reset     (reset),
        .operation (mulOperation),
        .a         (mulA),
        .b         (mulB),
        .hi        (hi),
        .lo        (lo),
        .product   (product),
        .status    (mulFlags)
    );

endmodule

`default_nettype wire

/* test/executeStageTb.sv */
// Execute stage testbench.
// Drives the stage one instruction per cycle and checks the registered
// outputs against a reference model that keeps its own HI/LO copy.

`timescale 1ns/10ps
`default_nettype none

module executeStageTb
    import execPkg::*;
();

    typedef struct packed {
        logic [31:0] value;
        flags        status;
    } outcome;

    localparam int edgeTimeout = 40; // Half-ns polling steps per clock edge.

    logic        Clock;
    logic        reset;
    logic        ALUOp;
    logic        MULOp;
    logic        Jump;
    logic        Branch;
    logic        ALUSrc;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immediate;
    logic [4:0]  shamt;
    funcField    func;
    memCtrl      memIn;
    logic [31:0] result;
    flags        flagsOut;
    memCtrl      memOut;
    logic [31:0] pcOut;

    // Expected outputs of the instruction in flight.
    logic [31:0] expResult;
    flags        expFlags;
    memCtrl      expMem;
    logic [31:0] expPc;
    logic [31:0] hiModel;
    logic [31:0] loModel;

    integer      seed = 22030;
    int          edgeCount = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    int          testNumber = 0;
    int          testChecks;
    int          testErrors;
    logic [31:0] nextPc;
    string       label;

    specialFunc aluCodes [18] = '{SLL, SRL, SRA, SLLV, SRLV, SRAV, ADD, ADDU, SUB, SUBU,
                                  AND, OR, XOR, NOR, SLT, SLTU, ADD, SUB};

    executeStage dut (
        .Clock, .reset, .ALUOp, .MULOp, .Jump, .Branch, .ALUSrc,
        .pc, .a, .b, .immediate, .shamt, .func, .memIn,
        .result, .flagsOut, .memOut, .pcOut
    );

    initial
    begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    always @(posedge Clock)
        edgeCount <= edgeCount + 1;

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic outcome referenceAlu(input specialFunc code, input logic [31:0] x,
                                            input logic [31:0] y, input logic [4:0] sa);
        outcome      o;
        logic [32:0] wide;
        logic [4:0]  amount;
        o = '0;
        amount = (code inside {SLLV, SRLV, SRAV}) ? x[4:0] : sa;
        case (code)
            SLL, SLLV: o.value = y << amount;
            SRL, SRLV: o.value = y >> amount;
            SRA, SRAV: o.value = (y >> amount) | (~(32'hFFFF_FFFF >> amount) & {32{y[31]}});
            ADD, ADDU:
            begin
                wide = {1'b0, x} + {1'b0, y};
                o.value = wide[31:0];
                o.status.carry = wide[32];
                if (code == ADD)
                    o.status.overflow = (x[31] == y[31]) && (o.value[31] != x[31]);
            end
            SUB, SUBU:
            begin
                o.value = x - y;
                o.status.carry = (x >= y); // No borrow.
                if (code == SUB)
                    o.status.overflow = (x[31] != y[31]) && (o.value[31] != x[31]);
            end
            AND:     o.value = x & y;
            OR:      o.value = x | y;
            XOR:     o.value = x ^ y;
            NOR:     o.value = ~(x | y);
            SLT:     o.value = {31'd0, $signed(x) < $signed(y)};
            SLTU:    o.value = {31'd0, x < y};
            default: o.value = '0;
        endcase
        o.status.zero = (o.value == 32'd0);
        o.status.negative = o.value[31];
        return o;
    endfunction

    // Leading bits equal to bitValue, scanning down from bit 31.
    function automatic logic [31:0] leadingCount(input logic [31:0] value, input logic bitValue);
        logic [31:0] count;
        logic        counting;
        count = '0;
        counting = 1'b1;
        for (int i = 31; i >= 0; i--)
        begin
            if (counting && value[i] == bitValue)
                count++;
            else
                counting = 1'b0;
        end
        return count;
    endfunction

    task automatic predict();
        logic [31:0] opB;
        logic [63:0] acc;
        logic [63:0] sp;
        logic [63:0] up;
        logic [63:0] nv;
        logic [64:0] wide;
        logic        ovf;
        logic        writes;
        outcome      o;
        opB = ALUSrc ? immediate : b;
        acc = {hiModel, loModel};
        sp = $signed({{32{a[31]}}, a}) * $signed({{32{opB[31]}}, opB});
        up = {32'd0, a} * {32'd0, opB};
        nv = acc;
        ovf = 1'b0;
        writes = 1'b0;
        expResult = '0;
        expFlags = '0;
        expMem = memIn;
        expPc = pc;
        if (ALUOp)
        begin
            case (func.special)
                MULT:
                begin
                    nv = sp;
                    writes = 1'b1;
                end
                MULTU:
                begin
                    nv = up;
                    writes = 1'b1;
                end
                MTHI:
                begin
                    nv = {a, loModel};
                    writes = 1'b1;
                end
                MTLO:
                begin
                    nv = {hiModel, a};
                    writes = 1'b1;
                end
                MFHI:     expResult = hiModel;
                MFLO:     expResult = loModel;
                JR, JALR: expResult = pc + 32'd8;
                default:
                begin
                    o = referenceAlu(func.special, a, opB, shamt);
                    expResult = o.value;
                    expFlags = o.status;
                end
            endcase
        end
        else if (MULOp)
        begin
            case (func.special2)
                MUL:
                begin
                    expResult = sp[31:0];
                    expFlags = '{carry: 1'b0, zero: (sp[31:0] == 32'd0),
                                 overflow: !((&sp[63:31]) || !(|sp[63:31])),
                                 negative: sp[31]};
                end
                MADD:
                begin
                    wide = {acc[63], acc} + {sp[63], sp};
                    nv = wide[63:0];
                    ovf = wide[64] ^ wide[63];
                    writes = 1'b1;
                end
                MSUB:
                begin
                    wide = {acc[63], acc} - {sp[63], sp};
                    nv = wide[63:0];
                    ovf = wide[64] ^ wide[63];
                    writes = 1'b1;
                end
                MADDU:
                begin
                    nv = acc + up;
                    writes = 1'b1;
                end
                MSUBU:
                begin
                    nv = acc - up;
                    writes = 1'b1;
                end
                CLZ, CLO:
                begin
                    expResult = leadingCount(a, func.special2 == CLO);
                    expFlags = '{carry: 1'b0, zero: (expResult == 32'd0),
                                 overflow: 1'b0, negative: expResult[31]};
                end
                default:  expResult = '0;
            endcase
        end
        else if (Branch)
        begin
            o = referenceAlu(SUB, a, opB, 5'd0);
            expResult = o.value;
            expFlags = o.status;
        end
        if (writes)
        begin
            expFlags = '{carry: 1'b0, zero: (nv == 64'd0), overflow: ovf, negative: nv[63]};
            expMem.regWrite = 1'b0;
            {hiModel, loModel} = nv;
        end
        if (Jump)
        begin
            expResult = pc + 32'd8;
            expFlags = '0;
            expMem.regWrite = 1'b1;
        end
    endtask

    // ------------------------------
    // Sequencing and checking
    // ------------------------------
    // Returns 1 ns after the next rising edge.
    task automatic waitEdge();
        int startCount;
        int guard;
        startCount = edgeCount;
        guard = 0;
        while (edgeCount == startCount && guard < edgeTimeout)
        begin
            #0.5;
            guard++;
        end
        #0.5;
        if (edgeCount == startCount)
        begin
            $display("Timeout: the clock made no rising edge within %0d ns", edgeTimeout / 2);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic checkOutputs();
        checkCount++;
        assert (result === expResult && flagsOut === expFlags &&
                memOut === expMem && pcOut === expPc)
        else
        begin
            errorCount++;
            $display("** Error at %0t ns: %s gave %h %b %b %h, expected %h %b %b %h",
                     $time, label, result, flagsOut, memOut, pcOut,
                     expResult, expFlags, expMem, expPc);
        end
    endtask

    task automatic issue();
        predict();
        waitEdge();
        checkOutputs();
    endtask

    function automatic logic [31:0] randomWord();
        return $random(seed);
    endfunction

    task automatic clearControls();
        ALUOp = 1'b0;
        MULOp = 1'b0;
        Jump = 1'b0;
        Branch = 1'b0;
        ALUSrc = 1'b0;
        func = '0;
        immediate = '0;
        shamt = '0;
        pc = nextPc;
        nextPc = nextPc + 32'd4;
        memIn = {1'b1, 2'(randomWord())}; // Memory controls pass through.
    endtask

    task automatic runSpecial(input specialFunc code, input logic [31:0] x, input logic [31:0] y,
                              input logic src, input logic [31:0] imm, input logic [4:0] sa);
        clearControls();
        ALUOp = 1'b1;
        func.special = code;
        a = x;
        b = y;
        ALUSrc = src;
        immediate = imm;
        shamt = sa;
        label = code.name();
        issue();
    endtask

    task automatic runSpecial2(input special2Func code, input logic [31:0] x, input logic [31:0] y);
        clearControls();
        MULOp = 1'b1;
        func.special2 = code;
        a = x;
        b = y;
        label = code.name();
        issue();
    endtask

    task automatic runBranch(input logic [31:0] x, input logic [31:0] y, input logic src);
        clearControls();
        Branch = 1'b1;
        a = x;
        b = y;
        ALUSrc = src;
        immediate = y;
        label = "BRANCH";
        issue();
    endtask

    task automatic readHiLo();
        runSpecial(MFHI, '0, '0, 1'b0, '0, '0);
        runSpecial(MFLO, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic beginTest();
        testNumber++;
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    task automatic endTest(input string name);
        $display("Test %0d (%s): %0d checks, %0d errors", testNumber, name,
                 checkCount - testChecks, errorCount - testErrors);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial
    begin
        reset = 1'b1;
        ALUOp = 1'b0;
        MULOp = 1'b0;
        Jump = 1'b0;
        Branch = 1'b0;
        ALUSrc = 1'b0;
        pc = '0;
        a = '0;
        b = '0;
        immediate = '0;
        shamt = '0;
        func = '0;
        memIn = '0;
        hiModel = '0;
        loModel = '0;
        nextPc = 32'h0040_0000;
        label = "RESET";

        repeat (8)
            waitEdge();

        // Outputs held at zero, then one idle cycle after release.
        beginTest();
        expResult = '0;
        expFlags = '0;
        expMem = '0;
        expPc = '0;
        checkOutputs();
        reset = 1'b0;
        issue();
        endTest("reset");

        beginTest();
        runSpecial(ADD, 32'h7FFF_FFFF, 32'h0000_0001, 1'b0, '0, '0);
        runSpecial(ADD, 32'h8000_0000, 32'h8000_0000, 1'b0, '0, '0);
        runSpecial(ADDU, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0, '0, '0);
        runSpecial(SUB, 32'h8000_0000, 32'h0000_0001, 1'b0, '0, '0);
        runSpecial(SUBU, 32'h0000_0000, 32'h0000_0001, 1'b0, '0, '0);
        runSpecial(SUB, 32'h0000_1234, 32'h0000_1234, 1'b0, '0, '0);
        runSpecial(SLT, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0, '0, '0);
        runSpecial(SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0, '0, '0);
        runSpecial(SRA, 32'h0, 32'h8000_00F0, 1'b0, '0, 5'd4);
        runSpecial(SRAV, 32'd31, 32'h8000_0000, 1'b0, '0, '0);
        repeat (80)
            runSpecial(aluCodes[$unsigned($random(seed)) % 18], randomWord(), randomWord(),
                       1'(randomWord()), randomWord(), 5'(randomWord()));
        endTest("ALU operations");

        beginTest();
        repeat (4)
        begin
            runSpecial(MULT, randomWord(), randomWord(), 1'b0, '0, '0);
            readHiLo();
            runSpecial(MULTU, randomWord(), randomWord(), 1'b0, '0, '0);
            readHiLo();
            runSpecial2(MADD, randomWord(), randomWord());
            readHiLo();
            runSpecial2(MADDU, randomWord(), randomWord());
            readHiLo();
            runSpecial2(MSUB, randomWord(), randomWord());
            readHiLo();
            runSpecial2(MSUBU, randomWord(), randomWord());
            readHiLo();
        end
        runSpecial(MULT, 32'hFFFF_FFFF, 32'h0, 1'b1, 32'h0000_0003, '0);
        readHiLo();
        // Accumulator overflow in both directions.
        runSpecial(MTHI, 32'h7FFF_FFFF, '0, 1'b0, '0, '0);
        runSpecial(MTLO, 32'hFFFF_FFFF, '0, 1'b0, '0, '0);
        runSpecial2(MADD, 32'd1, 32'd1);
        readHiLo();
        runSpecial2(MSUB, 32'd1, 32'd1);
        readHiLo();
        endTest("HI/LO multiply");

        beginTest();
        repeat (6)
        begin
            runSpecial(MTHI, randomWord(), '0, 1'b0, '0, '0);
            runSpecial(MFHI, '0, '0, 1'b0, '0, '0);
            runSpecial(MTLO, randomWord(), '0, 1'b0, '0, '0);
            runSpecial(MFLO, '0, '0, 1'b0, '0, '0);
        end
        endTest("HI/LO moves");

        beginTest();
        runSpecial2(MUL, 32'h0, 32'h1234_5678);
        runSpecial2(MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        runSpecial2(MUL, 32'h0001_0000, 32'h0001_0000);
        runSpecial2(MUL, 32'h7FFF_FFFF, 32'h0000_0002);
        runSpecial2(CLZ, 32'h0, '0);
        runSpecial2(CLZ, 32'hFFFF_FFFF, '0);
        runSpecial2(CLZ, 32'h0000_0001, '0);
        runSpecial2(CLO, 32'hFFFF_FFFF, '0);
        runSpecial2(CLO, 32'h0, '0);
        runSpecial2(CLO, 32'hF000_0000, '0);
        repeat (10)
        begin
            runSpecial2(MUL, randomWord(), randomWord());
            runSpecial2(CLZ, randomWord() >> (randomWord() & 31), '0);
            runSpecial2(CLO, ~(randomWord() >> (randomWord() & 31)), '0);
        end
        endTest("SPECIAL2 operations");

        beginTest();
        clearControls();
        Jump = 1'b1;
        memIn.regWrite = 1'b0; // Link write must be forced.
        label = "JUMP";
        issue();
        runSpecial(JALR, randomWord(), '0, 1'b0, '0, '0);
        runSpecial(JR, randomWord(), '0, 1'b0, '0, '0);
        runBranch(32'h0000_00A5, 32'h0000_00A5, 1'b0);
        runBranch(32'h0000_00A5, 32'h0000_00A4, 1'b0);
        runBranch(32'h8000_0000, 32'h8000_0000, 1'b1);
        runBranch(32'h8000_0000, 32'h0000_0001, 1'b1);
        endTest("jump and branch");

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
logic/execPkg.sv
logic/aluUnit.sv
logic/mulUnit.sv
logic/execControl.sv
logic/executeStage.sv
test/executeStageTb.sv

/* Makefile */
# Verilator build and run for the execute stage testbench.
# Any variable can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= executeStageTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASSTEXT  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
